// File: all.f
common/branch_pkg.sv
verilog/address_decoder.sv
branch_check/branch_table.sv
branch_check/branch_condition.sv
branch_check/branch_check.sv
verilog/branch_check_mapped.sv
dv/branch_check_asserts.sv
dv/branch_check_mapped_tb.sv

// File: branch_check/branch_check.sv
// Round-robin branch core; one-cycle decision latency, thread 0 issues in the first cycle after reset
`default_nettype none
`timescale 1ns/1ps

module branch_check
    import branch_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  pc_t    pc,
    input  flags_t flags,
    input  logic   io_ready_previous,
    input  logic   wren_origin,
    input  logic   wren_destination,
    input  logic   wren_condition,
    input  addr_t  write_addr,
    input  pc_t    origin_data,
    input  pc_t    destination_data,
    input  cond_t  condition_data,
    output pc_t    branch_destination,
    output logic   jump
);

    thread_t thread;
    pc_t     origin;
    pc_t     destination;
    cond_t   condition;
    logic    condition_met;
    logic    origin_match;
    logic    take_branch;

    // tracks which thread owns the instruction issuing this cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            thread <= '0;
        end else if (thread == thread_t'(THREAD_COUNT - 1)) begin
            thread <= '0;
        end else begin
            thread <= thread + thread_t'(1);
        end
    end

    branch_table #(.width(PC_WIDTH)) origin_table (
        .clock      (clock),
        .reset      (reset),
        .wren       (wren_origin),
        .write_addr (write_addr),
        .write_data (origin_data),
        .thread     (thread),
        .read_data  (origin)
    );

    branch_table #(.width(PC_WIDTH)) destination_table (
        .clock      (clock),
        .reset      (reset),
        .wren       (wren_destination),
        .write_addr (write_addr),
        .write_data (destination_data),
        .thread     (thread),
        .read_data  (destination)
    );

    branch_table #(.width(COND_WIDTH)) condition_table (
        .clock      (clock),
        .reset      (reset),
        .wren       (wren_condition),
        .write_addr (write_addr),
        .write_data (condition_data),
        .thread     (thread),
        .read_data  (condition)
    );

    branch_condition condition_eval (
        .condition     (condition),
        .flags         (flags),
        .condition_met (condition_met)
    );

    // an annulled origin instruction must not branch
    assign origin_match = (pc == origin);
    assign take_branch  = origin_match && io_ready_previous && condition_met;

    // destination is forced to zero so the PC path can OR it in without a mux
    always_ff @(posedge clock) begin
        if (reset) begin
            jump               <= 1'b0;
            branch_destination <= '0;
        end else begin
            jump               <= take_branch;
            branch_destination <= take_branch ? destination : '0;
        end
    end

endmodule

`default_nettype wire

// File: branch_check/branch_condition.sv
// Pure decode of the eight condition codes against Z,N,C,V flags
`default_nettype none
`timescale 1ns/1ps

module branch_condition
    import branch_pkg::*;
(
    input  cond_t  condition,
    input  flags_t flags,
    output logic   condition_met
);

    logic zero;
    logic negative;
    logic carry;
    logic overflow;

    assign zero     = flags[FLAG_ZERO];
    assign negative = flags[FLAG_NEGATIVE];
    assign carry    = flags[FLAG_CARRY];
    assign overflow = flags[FLAG_OVERFLOW];

    always_comb begin
        condition_met = 1'b0;
        case (condition)
            COND_NEVER:    condition_met = 1'b0;
            COND_ALWAYS:   condition_met = 1'b1;
            COND_ZERO:     condition_met = zero;
            COND_NOT_ZERO: condition_met = !zero;
            COND_NEGATIVE: condition_met = negative;
            // strictly greater than zero
            COND_POSITIVE: condition_met = !negative && !zero;
            COND_CARRY:    condition_met = carry;
            COND_OVERFLOW: condition_met = overflow;
            default:       condition_met = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: branch_check/branch_table.sv
// One entry per thread, indexed by the low address bits; read for the same entry sees the old value
`default_nettype none
`timescale 1ns/1ps

module branch_table
    import branch_pkg::*;
#(
    parameter int width = 1
)
(
    input  logic             clock,
    input  logic             reset,
    input  logic             wren,
    input  addr_t            write_addr,
    input  logic [width-1:0] write_data,
    input  thread_t          thread,
    output logic [width-1:0] read_data
);

    logic [width-1:0] entries [THREAD_COUNT];
    thread_t          write_index;

    // the decoder has already checked the range, only the thread part matters here
    assign write_index = write_addr[THREAD_ADDR_WIDTH-1:0];

    always_ff @(posedge clock) begin
        if (reset) begin
            entries <= '{default: '0};
        end else if (wren) begin
            entries[write_index] <= write_data;
        end
    end

    // asynchronous read so the current thread's entry is ready within its issue cycle
    assign read_data = entries[thread];

endmodule

`default_nettype wire

// File: common/branch_pkg.sv
// Widths, address map, write word field offsets and condition codes; flags arrive as 4 bits Z,N,C,V
`default_nettype none

package branch_pkg;

    localparam int PC_WIDTH          = 10;
    localparam int WORD_WIDTH        = 36;
    localparam int D_OPERAND_WIDTH   = 10;
    localparam int THREAD_COUNT      = 8;
    localparam int THREAD_ADDR_WIDTH = 3;
    localparam int FLAGS_WIDTH       = 4;
    localparam int COND_WIDTH        = 3;

    typedef logic [PC_WIDTH-1:0]          pc_t;
    typedef logic [WORD_WIDTH-1:0]        word_t;
    typedef logic [D_OPERAND_WIDTH-1:0]   addr_t;
    typedef logic [THREAD_ADDR_WIDTH-1:0] thread_t;
    typedef logic [FLAGS_WIDTH-1:0]       flags_t;
    typedef logic [COND_WIDTH-1:0]        cond_t;

    // bit positions inside a flags word
    localparam int FLAG_ZERO     = 0;
    localparam int FLAG_NEGATIVE = 1;
    localparam int FLAG_CARRY    = 2;
    localparam int FLAG_OVERFLOW = 3;

    // each table base is aligned to THREAD_COUNT, so the low address bits pick the thread
    localparam addr_t ORIGIN_BASE      = addr_t'('h3E0);
    localparam addr_t DESTINATION_BASE = addr_t'('h3E8);
    localparam addr_t CONDITION_BASE   = addr_t'('h3F0);

    // where each table's field sits inside the ALU write word
    localparam int ORIGIN_OFFSET      = 0;
    localparam int DESTINATION_OFFSET = 10;
    localparam int CONDITION_OFFSET   = 20;

    localparam cond_t COND_NEVER    = cond_t'(0);
    localparam cond_t COND_ALWAYS   = cond_t'(1);
    localparam cond_t COND_ZERO     = cond_t'(2);
    localparam cond_t COND_NOT_ZERO = cond_t'(3);
    localparam cond_t COND_NEGATIVE = cond_t'(4);
    // positive means neither negative nor zero
    localparam cond_t COND_POSITIVE = cond_t'(5);
    localparam cond_t COND_CARRY    = cond_t'(6);
    localparam cond_t COND_OVERFLOW = cond_t'(7);

endpackage

`default_nettype wire

// File: dv/branch_check_asserts.sv
// Bound to branch_check_mapped; needs assertion support turned on in the simulator
`default_nettype none
`timescale 1ns/1ps

module branch_check_asserts
    import branch_pkg::*;
(
    input logic clock,
    input logic reset,
    input logic io_ready_previous,
    input logic jump,
    input pc_t  branch_destination
);

    // outputs clear on reset, so nothing can branch right after it
    jump_low_after_reset: assert property (
        @(posedge clock) reset |=> !jump
    ) else $error("jump was high in the cycle after reset");

    // an annulled origin instruction never branches
    jump_needs_issue: assert property (
        @(posedge clock) disable iff (reset) jump |-> $past(io_ready_previous)
    ) else $error("jump rose although the origin instruction was not issued");

    destination_zero_without_jump: assert property (
        @(posedge clock) disable iff (reset) !jump |-> (branch_destination == '0)
    ) else $error("branch_destination is nonzero while jump is low");

endmodule

bind branch_check_mapped branch_check_asserts branch_asserts (
    .clock              (clock),
    .reset              (reset),
    .io_ready_previous  (io_ready_previous),
    .jump               (jump),
    .branch_destination (branch_destination)
);

`default_nettype wire

// File: dv/branch_check_mapped_tb.sv
// Run from the project root; stim lines are thread slots in round-robin order, padded in blocks of 8
`default_nettype none
`timescale 1ns/1ps

module branch_check_mapped_tb
    import branch_pkg::*;
;

    localparam int CLOCK_PERIOD  = 4;
    localparam int RESET_CYCLES  = 5;
    localparam int MAX_LINES     = 64;
    localparam int FIELDS        = 7;
    localparam int PAD_CYCLES    = THREAD_COUNT;
    localparam int MARGIN_CYCLES = 20;

    logic   clock;
    logic   reset;
    pc_t    pc;
    flags_t flags;
    logic   io_ready_previous;
    addr_t  alu_write_addr;
    word_t  alu_write_data;
    pc_t    branch_destination;
    logic   jump;

    word_t stim_words [MAX_LINES*FIELDS];
    int    line_count;
    logic  stim_loaded;
    int    error_count;
    int    check_count;

    // expectation of the previous cycle, compared once its registered result is out
    logic  pending_valid;
    logic  pending_jump;
    pc_t   pending_dest;
    string pending_name;

    branch_check_mapped UUT (
        .clock              (clock),
        .reset              (reset),
        .pc                 (pc),
        .flags              (flags),
        .io_ready_previous  (io_ready_previous),
        .alu_write_addr     (alu_write_addr),
        .alu_write_data     (alu_write_data),
        .branch_destination (branch_destination),
        .jump               (jump)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // outputs are stable at the falling edge, half a cycle after the decision was registered
    task automatic check_pending();
        @(negedge clock);
        if (pending_valid) begin
            check_value({pending_name, " jump"}, 32'(pending_jump), 32'(jump));
            check_value({pending_name, " destination"}, 32'(pending_dest),
                        32'(branch_destination));
        end
        pending_valid = 1'b0;
    endtask

    // called at a rising edge, returns at the next one
    task automatic apply_cycle(input addr_t addr, input word_t data, input pc_t issue_pc,
                               input flags_t issue_flags, input logic ready,
                               input logic exp_jump, input pc_t exp_dest, input string name);
        alu_write_addr    <= addr;
        alu_write_data    <= data;
        pc                <= issue_pc;
        flags             <= issue_flags;
        io_ready_previous <= ready;
        check_pending();
        pending_valid = 1'b1;
        pending_jump  = exp_jump;
        pending_dest  = exp_dest;
        pending_name  = name;
        @(posedge clock);
    endtask

    // origins sit at 0x100 and above, so a pc below that can never branch
    task automatic pad_cycle(input int index);
        apply_cycle(addr_t'($urandom_range(0, 32'h3DF)), word_t'({$urandom, $urandom}),
                    pc_t'($urandom_range(0, 32'hFF)), flags_t'($urandom), 1'($urandom),
                    1'b0, '0, $sformatf("pad %0d", index));
    endtask

    initial begin
        int base;
        void'($urandom(85600));
        error_count       = 0;
        check_count       = 0;
        pending_valid     = 1'b0;
        stim_loaded       = 1'b0;
        reset             = 1'b1;
        pc                = '0;
        flags             = '0;
        io_ready_previous = 1'b0;
        alu_write_addr    = '0;
        alu_write_data    = '0;

        // an all-ones address word marks the end of the data
        for (int i = 0; i < MAX_LINES * FIELDS; i++) begin
            stim_words[i] = '1;
        end
        $readmemh("dv/branch_stim.txt", stim_words);
        line_count = 0;
        while (line_count < MAX_LINES && stim_words[line_count * FIELDS] != '1) begin
            line_count++;
        end
        stim_loaded = 1'b1;
        if (line_count == 0) begin
            error_count++;
            $display("no stimulus lines could be read from dv/branch_stim.txt");
        end

        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        for (int line_index = 0; line_index < line_count; line_index++) begin
            base = line_index * FIELDS;
            apply_cycle(stim_words[base][D_OPERAND_WIDTH-1:0], stim_words[base + 1],
                        stim_words[base + 2][PC_WIDTH-1:0],
                        stim_words[base + 3][FLAGS_WIDTH-1:0], stim_words[base + 4][0],
                        stim_words[base + 5][0], stim_words[base + 6][PC_WIDTH-1:0],
                        $sformatf("stim line %0d", line_index));
            // whole blocks of padding keep the next directed line in its thread slot
            if (line_index % THREAD_COUNT == THREAD_COUNT - 1) begin
                for (int p = 0; p < PAD_CYCLES; p++) begin
                    pad_cycle(line_index * PAD_CYCLES + p);
                end
            end
        end
        check_pending();

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        int timeout_cycles;
        wait (stim_loaded);
        timeout_cycles = RESET_CYCLES + line_count + MARGIN_CYCLES
                       + (line_count / THREAD_COUNT + 1) * PAD_CYCLES;
        #(timeout_cycles * CLOCK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", timeout_cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/branch_stim.txt
// columns: write_addr write_data pc flags io_ready_previous expected_jump expected_destination
// one line per cycle in hex, line n issues for thread n mod 8
3E0 80100 000 F 1 0 000
3E1 88110 000 F 1 0 000
3E2 90120 000 F 1 0 000
3E3 98130 000 F 1 0 000
3E4 A0140 000 F 1 0 000
3E5 A8150 000 F 1 0 000
3E6 B0160 000 F 1 0 000
3E7 B8170 000 F 1 0 000
3E8 80100 100 F 1 0 000
3E9 88110 110 F 1 0 000
3EA 90120 120 F 1 0 000
3EB 98130 130 F 1 0 000
3EC A0140 140 F 1 0 000
3ED A8150 150 F 1 0 000
3EE B0160 160 F 1 0 000
3EF B8170 170 F 1 0 000
3F1 100000 100 0 1 0 000
3F2 100000 110 0 1 1 220
3F3 100000 120 0 1 1 240
3F4 100000 130 0 1 1 260
3F5 100000 140 0 0 0 000
3F6 100000 150 0 1 1 2A0
3F7 100000 160 0 1 1 2C0
3F0 100000 170 0 1 1 2E0
3F1 100000 100 F 1 1 200
3F2 200000 110 0 1 1 220
3F3 300000 120 1 1 1 240
3F4 400000 130 0 1 1 260
3F5 500000 140 2 1 1 280
3F6 600000 150 4 1 1 2A0
3F7 700000 160 4 1 1 2C0
3F0 000000 170 8 1 1 2E0
3F9 100000 100 F 1 0 000
3DA 100000 110 F 1 1 220
3FB 100000 120 E 1 0 000
3DC 100000 130 1 1 0 000
3FD 100000 140 D 1 0 000
3DE 100000 150 1 1 0 000
3FF 100000 160 B 1 0 000
000 100000 170 7 1 0 000

// File: run.sh
#!/usr/bin/env bash
# Builds and runs the branch unit testbench with Verilator from the project root
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module branch_check_mapped_tb -f all.f -o branch_tb --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/branch_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Simulation PASSED$"; then
    exit 0
fi
exit 1

// File: verilog/address_decoder.sv
// Combinational range decoder; base+count must fit the address space, clock is not used
`default_nettype none
`timescale 1ns/1ps

module address_decoder
    import branch_pkg::*;
#(
    parameter addr_t base  = '0,
    parameter int    count = 1
)
(
    input  logic  clock,
    input  addr_t addr,
    output logic  hit
);

    // clock only keeps the port list shared with a registered decoder
    localparam int unsigned range_low  = 32'(base);
    localparam int unsigned range_high = range_low + count;

    logic [31:0] addr_wide;

    assign addr_wide = 32'(addr);
    assign hit       = (addr_wide >= range_low) && (addr_wide < range_high);

endmodule

`default_nettype wire

// File: verilog/branch_check_mapped.sv
// Memory-mapped branch unit top; writes are single-cycle with no strobe other than the address range
`default_nettype none
`timescale 1ns/1ps

module branch_check_mapped
    import branch_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  pc_t    pc,
    input  flags_t flags,
    input  logic   io_ready_previous,
    input  addr_t  alu_write_addr,
    input  word_t  alu_write_data,
    output pc_t    branch_destination,
    output logic   jump
);

    logic  wren_origin;
    logic  wren_destination;
    logic  wren_condition;
    pc_t   origin_data;
    pc_t   destination_data;
    cond_t condition_data;

    // all three fields share one write word so a single store can set any table
    assign origin_data      = alu_write_data[ORIGIN_OFFSET +: PC_WIDTH];
    assign destination_data = alu_write_data[DESTINATION_OFFSET +: PC_WIDTH];
    assign condition_data   = alu_write_data[CONDITION_OFFSET +: COND_WIDTH];

    address_decoder #(.base(ORIGIN_BASE), .count(THREAD_COUNT)) origin_decoder (
        .clock (clock),
        .addr  (alu_write_addr),
        .hit   (wren_origin)
    );

    address_decoder #(.base(DESTINATION_BASE), .count(THREAD_COUNT)) destination_decoder (
        .clock (clock),
        .addr  (alu_write_addr),
        .hit   (wren_destination)
    );

    address_decoder #(.base(CONDITION_BASE), .count(THREAD_COUNT)) condition_decoder (
        .clock (clock),
        .addr  (alu_write_addr),
        .hit   (wren_condition)
    );

    branch_check core (
        .clock              (clock),
        .reset              (reset),
        .pc                 (pc),
        .flags              (flags),
        .io_ready_previous  (io_ready_previous),
        .wren_origin        (wren_origin),
        .wren_destination   (wren_destination),
        .wren_condition     (wren_condition),
        .write_addr         (alu_write_addr),
        .origin_data        (origin_data),
        .destination_data   (destination_data),
        .condition_data     (condition_data),
        .branch_destination (branch_destination),
        .jump               (jump)
    );

endmodule

`default_nettype wire
